// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ps2_kbd
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
+incdir+verification
verilog/ps2_pkg.sv
verilog/ps2_edge_timer.sv
verilog/ps2_frame_fsm.sv
verilog/scan_fifo.sv
verilog/kbd_axil_regs.sv
verilog/ps2_kbd_top.sv
verification/tb_ps2_kbd.sv

// ==== verification/ps2_tb_tasks.svh ====
// PS/2 testbench driver and check tasks
`ifndef PS2_TB_TASKS_SVH
`define PS2_TB_TASKS_SVH

localparam int PS2_HALF     = 40;           // ps2_clk half period in kb_clk cycles
localparam int AXI_WAIT     = 50;           // handshake limit in cycles
localparam int FR_GOOD      = 0;
localparam int FR_BAD_PAR   = 1;
localparam int FR_BAD_START = 2;
localparam int FR_BAD_STOP  = 3;

task automatic wait_cycles(input int n);
    repeat (n) @(posedge kb_clk);
    #1;                                     // drive point, just past the edge
endtask

task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
        error_count++;
        $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
    end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    check_hex(name, 32'(got), 32'(exp));
endtask

task automatic check_cond(input logic ok, input string what);
    check_count++;
    assert (ok) else begin
        error_count++;
        $display("ERROR: %s", what);
    end
endtask

// keyboard side, data set mid high phase, bits go lsb first
task automatic send_frame(input scan_code_t code, input int kind, input int n_bits);
    ps2_frame_u frm;
    frm.fields.start  = (kind == FR_BAD_START);
    frm.fields.data   = code;
    frm.fields.parity = (~^code) ^ (kind == FR_BAD_PAR); // odd unless spoiled
    frm.fields.stop   = (kind != FR_BAD_STOP);
    for (int i = 0; i < n_bits; i++) begin
        ps2_data = frm.raw[i];
        wait_cycles(PS2_HALF / 2);
        ps2_clk = 1'b0;                     // receiver samples on this fall
        wait_cycles(PS2_HALF);
        ps2_clk = 1'b1;
        wait_cycles(PS2_HALF / 2);
    end
    ps2_data = 1'b1;                        // bus back to idle
endtask

task automatic axi_read(input logic [AXIL_ADDR_W-1:0] addr,
                        output logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    logic taken;
    int   waited;
    araddr  = addr;
    arvalid = 1'b1;
    taken   = 1'b0;
    waited  = 0;
    while (!taken && waited < AXI_WAIT) begin
        taken = arready;                    // level held through the next edge
        wait_cycles(1);
        waited++;
    end
    arvalid = 1'b0;
    check_cond(taken, "read address was never accepted");
    waited = 0;
    while (!rvalid && waited < AXI_WAIT) begin
        wait_cycles(1);
        waited++;
    end
    check_cond(rvalid, "read response never arrived");
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    wait_cycles(1);
    rready = 1'b0;
endtask

task automatic axi_write(input logic [AXIL_ADDR_W-1:0] addr,
                         input logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    logic taken;
    int   waited;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    taken   = 1'b0;
    waited  = 0;
    while (!taken && waited < AXI_WAIT) begin
        taken = awready && wready;
        wait_cycles(1);
        waited++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check_cond(taken, "write address and data were never accepted");
    waited = 0;
    while (!bvalid && waited < AXI_WAIT) begin
        wait_cycles(1);
        waited++;
    end
    check_cond(bvalid, "write response never arrived");
    resp   = bresp;
    bready = 1'b1;
    wait_cycles(1);
    bready = 1'b0;
endtask

// poll STATUS until a code is queued
task automatic wait_ready();
    logic [AXIL_DATA_W-1:0] st;
    logic [1:0]             rsp;
    int                     tries;
    st    = '0;
    tries = 0;
    while (!st[0] && tries < 100) begin
        axi_read(REG_STATUS, st, rsp);
        tries++;
    end
    check_cond(st[0], "STATUS ready never rose after a frame");
endtask

`endif

// ==== verification/tb_ps2_kbd.sv ====
// PS/2 keyboard receiver testbench
`timescale 1ns/1ps
module tb_ps2_kbd;

    import ps2_pkg::*;

    localparam int FIFO_DEPTH      = 8;
    localparam int GAP_TIMEOUT     = 300;
    localparam int FRAME_COUNT     = 22;    // frames sent over all tests
    localparam int WATCHDOG_CYCLES = FRAME_COUNT * 1000 + 5000;

    logic                     kb_clk = 1'b0;
    logic                     rst;
    logic                     ps2_clk;
    logic                     ps2_data;
    logic [AXIL_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [AXIL_DATA_W-1:0]   wdata;
    logic [AXIL_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [AXIL_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [AXIL_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;
    int                       check_count;
    int                       error_count;

    `include "ps2_tb_tasks.svh"

    ps2_kbd_top #(.FIFO_DEPTH(FIFO_DEPTH), .GAP_TIMEOUT(GAP_TIMEOUT)) dut0 (
        .kb_clk, .rst, .ps2_clk, .ps2_data,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    always #5 kb_clk = ~kb_clk;             // 10 ns

    // ready in bit 0 and overflow in bit 1 with level in 7:4 and errors in 15:8
    function automatic logic [31:0] expect_status(input logic rdy, input logic ovf,
                                                  input logic [3:0] lvl, input logic [7:0] errs);
        return {16'd0, errs, lvl, 2'b00, ovf, rdy};
    endfunction

    function automatic logic [31:0] expect_data(input scan_code_t code);
        return {23'd0, 1'b1, code};         // valid bit 8 over the code
    endfunction

    task automatic test_single_frame();
        logic [31:0] rd;
        logic [1:0]  rsp;
        axi_read(REG_STATUS, rd, rsp);      // nothing queued out of reset
        check_hex("STATUS rdata", rd, expect_status(1'b0, 1'b0, 4'd0, 8'd0));
        send_frame(8'h1C, FR_GOOD, 11);
        wait_ready();
        axi_read(REG_DATA, rd, rsp);
        check_hex("DATA rdata", rd, 32'h0000_011C);
        check_resp("DATA rresp", rsp, RESP_OKAY);
        axi_read(REG_STATUS, rd, rsp);
        check_hex("STATUS rdata", rd, expect_status(1'b0, 1'b0, 4'd0, 8'd0));
    endtask

    task automatic test_burst_order();
        scan_code_t  codes [5];
        logic [31:0] rd;
        logic [1:0]  rsp;
        for (int i = 0; i < 5; i++) begin
            codes[i] = scan_code_t'($urandom);
            send_frame(codes[i], FR_GOOD, 11); // back to back with no reads
        end
        wait_ready();
        for (int i = 0; i < 5; i++) begin
            axi_read(REG_STATUS, rd, rsp);
            check_hex("STATUS.level", 32'(rd[7:4]), 32'(5 - i)); // codes still queued
            axi_read(REG_DATA, rd, rsp);
            check_hex("DATA rdata", rd, expect_data(codes[i]));
            check_resp("DATA rresp", rsp, RESP_OKAY);
        end
    endtask

    task automatic test_bad_frames();
        logic [31:0] rd;
        logic [1:0]  rsp;
        for (int k = FR_BAD_PAR; k <= FR_BAD_STOP; k++) begin
            send_frame(8'h5A, k, 11);
            axi_read(REG_STATUS, rd, rsp);
            check_hex("STATUS rdata", rd,
                      expect_status(1'b0, 1'b0, 4'd0, 8'(k - FR_BAD_PAR + 1)));
        end
        axi_write(REG_CONTROL, 32'h5, rsp); // keep rx on and clear errors
        check_resp("CONTROL bresp", rsp, RESP_OKAY);
        axi_read(REG_STATUS, rd, rsp);
        check_hex("STATUS rdata", rd, expect_status(1'b0, 1'b0, 4'd0, 8'd0));
    endtask

    task automatic test_overflow();
        scan_code_t  codes [9];
        logic [31:0] rd;
        logic [1:0]  rsp;
        for (int i = 0; i < 9; i++) begin
            codes[i] = scan_code_t'($urandom);
            send_frame(codes[i], FR_GOOD, 11);
        end
        wait_ready();
        axi_read(REG_STATUS, rd, rsp);
        check_hex("STATUS rdata", rd, expect_status(1'b1, 1'b1, 4'd8, 8'd0));
        for (int i = 0; i < 8; i++) begin
            axi_read(REG_DATA, rd, rsp);
            check_hex("DATA rdata", rd, expect_data(codes[i])); // ninth never queued
        end
        axi_read(REG_STATUS, rd, rsp);
        check_hex("STATUS rdata", rd, expect_status(1'b0, 1'b1, 4'd0, 8'd0));
        axi_write(REG_CONTROL, 32'h3, rsp); // clear overflow
        check_resp("CONTROL bresp", rsp, RESP_OKAY);
        axi_read(REG_STATUS, rd, rsp);
        check_hex("STATUS rdata", rd, expect_status(1'b0, 1'b0, 4'd0, 8'd0));
    endtask

    task automatic test_gap_abort();
        logic [31:0] rd;
        logic [1:0]  rsp;
        send_frame(8'h3A, FR_GOOD, 5);      // clock stops after 5 bits
        wait_cycles(GAP_TIMEOUT + 100);
        axi_read(REG_STATUS, rd, rsp);
        check_hex("STATUS rdata", rd, expect_status(1'b0, 1'b0, 4'd0, 8'd1));
        send_frame(8'h3A, FR_GOOD, 11);
        wait_ready();
        axi_read(REG_DATA, rd, rsp);
        check_hex("DATA rdata", rd, expect_data(8'h3A));
        axi_read(REG_STATUS, rd, rsp);
        check_hex("STATUS rdata", rd, expect_status(1'b0, 1'b0, 4'd0, 8'd1));
        axi_write(REG_CONTROL, 32'h5, rsp);
    endtask

    task automatic test_empty_unmapped_disable();
        logic [31:0] rd;
        logic [1:0]  rsp;
        axi_read(REG_DATA, rd, rsp);        // fifo empty here
        check_hex("DATA.valid", 32'(rd[8]), 32'h0);
        check_resp("DATA rresp", rsp, RESP_OKAY);
        axi_read(4'hC, rd, rsp);
        check_resp("unmapped rresp", rsp, RESP_SLVERR);
        axi_write(4'hC, 32'h0, rsp);        // would turn rx off if it hit CONTROL
        check_resp("unmapped bresp", rsp, RESP_SLVERR);
        axi_read(REG_CONTROL, rd, rsp);
        check_hex("CONTROL rdata", rd, 32'h1); // rx still enabled
        axi_read(REG_STATUS, rd, rsp);
        check_hex("STATUS rdata", rd, expect_status(1'b0, 1'b0, 4'd0, 8'd0));
        axi_write(REG_CONTROL, 32'h0, rsp); // receiver off
        send_frame(8'h2B, FR_GOOD, 11);
        axi_read(REG_STATUS, rd, rsp);
        check_hex("STATUS rdata", rd, expect_status(1'b0, 1'b0, 4'd0, 8'd0));
        axi_write(REG_CONTROL, 32'h1, rsp);
        send_frame(8'h2B, FR_GOOD, 11);     // back on so the frame lands again
        wait_ready();
        axi_read(REG_DATA, rd, rsp);
        check_hex("DATA rdata", rd, expect_data(8'h2B));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge kb_clk);
        $display("watchdog expired after %0d cycles, test sequence hung", WATCHDOG_CYCLES);
        $display("checks run %0d, errors %0d", check_count, error_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(79652));
        check_count = 0;
        error_count = 0;
        rst = 1'b1;
        ps2_clk = 1'b1;                     // idle bus is high
        ps2_data = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        wait_cycles(5);
        rst = 1'b0;
        check_cond(!awready && !wready && !arready && !bvalid && !rvalid,
                   "AXI handshake outputs not low after reset");
        wait_cycles(2);
        test_single_frame();
        test_burst_order();
        test_bad_frames();
        test_overflow();
        test_gap_abort();
        test_empty_unmapped_disable();
        $display("checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/kbd_axil_regs.sv ====
// keyboard AXI4-Lite register slave
`timescale 1ns/1ps
module kbd_axil_regs #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            kb_clk,
    input  logic                            rst,
    // write address and data
    input  logic [ps2_pkg::AXIL_ADDR_W-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [ps2_pkg::AXIL_DATA_W-1:0] wdata,
    input  logic [ps2_pkg::AXIL_DATA_W/8-1:0] wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    // write response
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    // read address and data
    input  logic [ps2_pkg::AXIL_ADDR_W-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [ps2_pkg::AXIL_DATA_W-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    // fifo and fsm side
    input  logic                            empty,
    input  logic [$clog2(FIFO_DEPTH):0]     level,
    input  ps2_pkg::scan_code_t             head_code,
    input  logic                            overflow,
    input  logic                            frame_err,
    output logic                            pop,
    output logic                            clear_overflow,
    output logic                            rx_enable
);

    import ps2_pkg::*;

    logic                     wr_fire;      // aw and w taken this cycle
    logic                     rd_fire;      // ar taken this cycle
    logic                     wr_mapped;
    logic                     wr_ctrl;
    logic [STAT_ERRCNT_W-1:0] err_cnt;      // saturating frame error count
    logic [7:0]               level_ext;
    logic [STAT_LEVEL_W-1:0]  level_field;
    logic [AXIL_DATA_W-1:0]   status_word;
    logic [AXIL_DATA_W-1:0]   rd_word;
    logic [1:0]               rd_resp;

    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    assign wr_mapped = (awaddr == REG_DATA) || (awaddr == REG_STATUS)
                    || (awaddr == REG_CONTROL); // data/status writes are ignored
    assign wr_ctrl   = wr_fire && (awaddr == REG_CONTROL) && wstrb[0];

    // side effects of the accepted transfers
    assign pop            = rd_fire && (araddr == REG_DATA) && !empty;
    assign clear_overflow = wr_ctrl && wdata[CTRL_CLR_OVF_BIT];

    // 4-bit level field, a full 16-deep fifo reads as 15
    assign level_ext   = 8'(level);
    assign level_field = (level_ext > 8'd15) ? 4'hF : level_ext[3:0];

    always_comb begin
        status_word = '0;
        status_word[STAT_READY_BIT] = !empty;
        status_word[STAT_OVF_BIT]   = overflow;
        status_word[STAT_LEVEL_LSB +: STAT_LEVEL_W]   = level_field;
        status_word[STAT_ERRCNT_LSB +: STAT_ERRCNT_W] = err_cnt;
    end

    // read mux, unmapped gives zero data and slverr
    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_DATA: begin
                rd_word[7:0]           = head_code;
                rd_word[DATA_VALID_BIT] = !empty;
            end
            REG_STATUS:  rd_word = status_word;
            REG_CONTROL: rd_word[CTRL_RX_EN_BIT] = rx_enable; // clear bits read 0
            default:     rd_resp = RESP_SLVERR;
        endcase
    end

    // write path, ready pulses once then response waits for bready
    always_ff @(posedge kb_clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready && !wr_fire;
            wready  <= awvalid && wvalid && !bvalid && !awready && !wr_fire;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read path, one address in flight
    always_ff @(posedge kb_clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= RESP_OKAY;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rresp  <= rd_resp;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge kb_clk) begin
        if (rd_fire) begin
            rdata <= rd_word;               // head code caught at the pop edge
        end
    end

    // control register and error counter
    always_ff @(posedge kb_clk) begin
        if (rst) begin
            rx_enable <= 1'b1;
            err_cnt   <= '0;
        end else begin
            if (wr_ctrl) begin
                rx_enable <= wdata[CTRL_RX_EN_BIT];
            end
            if (wr_ctrl && wdata[CTRL_CLR_ERR_BIT]) begin
                err_cnt <= '0;
            end else if (frame_err && (err_cnt != '1)) begin
                err_cnt <= err_cnt + 1'b1; // sticks at 255
            end
        end
    end

    a_rvalid_hold: assert property (@(posedge kb_clk) disable iff (rst)
        rvalid && !rready |=> rvalid);

endmodule

// ==== verilog/ps2_edge_timer.sv ====
// PS/2 line sync and bit-gap timer
`timescale 1ns/1ps
module ps2_edge_timer #(
    parameter int GAP_TIMEOUT = 5000        // kb_clk cycles without an edge
) (
    input  logic kb_clk,
    input  logic rst,
    input  logic ps2_clk,                   // async from keyboard
    input  logic ps2_data,                  // async from keyboard
    output logic sample_stb,                // one cycle per ps2_clk fall
    output logic bit_value,                 // data bit aligned to sample_stb
    output logic gap_expired                // one cycle, clock stalled mid frame
);

    localparam int GW = $clog2(GAP_TIMEOUT + 1); // gap counter width

    logic [2:0]    clk_sync;                // two sync stages plus edge stage
    logic [1:0]    data_sync;
    logic          clk_fall;
    logic [GW-1:0] gap_cnt;
    logic          armed;                   // an edge seen since last expiry

    assign clk_fall = clk_sync[2] & ~clk_sync[1]; // high then low

    always_ff @(posedge kb_clk) begin
        if (rst) begin
            clk_sync   <= 3'b111;           // idle bus is high
            data_sync  <= 2'b11;
            sample_stb <= 1'b0;
            bit_value  <= 1'b1;
        end else begin
            clk_sync   <= {clk_sync[1:0], ps2_clk};
            data_sync  <= {data_sync[0], ps2_data};
            sample_stb <= clk_fall;         // registered strobe, 3 cycles after fall
            bit_value  <= data_sync[1];     // same depth as the clock path
        end
    end

    // gap counter restarts on every falling edge and sticks at the limit
    always_ff @(posedge kb_clk) begin
        if (rst) begin
            gap_cnt     <= '0;
            armed       <= 1'b0;
            gap_expired <= 1'b0;
        end else begin
            gap_expired <= 1'b0;
            if (clk_fall) begin
                gap_cnt <= '0;
                armed   <= 1'b1;
            end else if (gap_cnt != GW'(GAP_TIMEOUT)) begin
                gap_cnt <= gap_cnt + 1'b1;
            end else if (armed) begin
                gap_expired <= 1'b1;        // single pulse per stall
                armed       <= 1'b0;
            end
        end
    end

    // strobe comes from a fall, expiry only when no fall, so never both
    a_stb_gap_excl: assert property (@(posedge kb_clk) disable iff (rst)
        !(sample_stb && gap_expired));

endmodule

// ==== verilog/ps2_frame_fsm.sv ====
// PS/2 frame assembler and checker
`timescale 1ns/1ps
module ps2_frame_fsm (
    input  logic                kb_clk,
    input  logic                rst,
    input  logic                sample_stb,  // one per ps2_clk fall
    input  logic                bit_value,
    input  logic                gap_expired, // clock stalled
    input  logic                rx_enable,   // low = track but discard
    output logic                push,        // good frame, one cycle
    output ps2_pkg::scan_code_t push_code,
    output logic                frame_err    // bad or aborted frame, one cycle
);

    import ps2_pkg::*;

    localparam logic [1:0] IDLE  = 2'd0;    // waiting for start bit
    localparam logic [1:0] SHIFT = 2'd1;    // taking data and parity
    localparam logic [1:0] CHECK = 2'd2;    // stop bit due, then verdict

    logic [1:0] state;
    logic [3:0] bit_cnt;                    // index of the next frame bit
    ps2_frame_u frame_q;                    // bits taken so far
    ps2_frame_u frame_w;                    // full word incl. the stop bit on the wire
    logic       frame_ok;

    // stop bit is checked straight off the line so the verdict costs one cycle
    always_comb begin
        frame_w.raw = {bit_value, frame_q.raw[9:0]};
        frame_ok    = !frame_w.fields.start
                   && frame_w.fields.stop
                   && (^{frame_w.fields.data, frame_w.fields.parity}); // odd parity
    end

    // shift register, payload only
    always_ff @(posedge kb_clk) begin
        if (sample_stb) begin
            frame_q.raw[bit_cnt] <= bit_value; // lsb first
        end
    end

    always_ff @(posedge kb_clk) begin
        push_code <= frame_w.fields.data;   // valid with push
    end

    always_ff @(posedge kb_clk) begin
        if (rst) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            push      <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            push      <= 1'b0;
            frame_err <= 1'b0;
            if (gap_expired) begin
                // clock stalled partway, drop what we have
                if (state != IDLE) begin
                    frame_err <= rx_enable;
                end
                state   <= IDLE;
                bit_cnt <= '0;
            end else if (sample_stb) begin
                case (state)
                    IDLE: begin
                        bit_cnt <= 4'd1;    // start bit stored
                        state   <= SHIFT;
                    end
                    SHIFT: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd9) begin
                            state <= CHECK; // parity stored, stop is next
                        end
                    end
                    CHECK: begin
                        push      <= rx_enable && frame_ok;
                        frame_err <= rx_enable && !frame_ok;
                        bit_cnt   <= '0;
                        state     <= IDLE;
                    end
                    default: begin
                        bit_cnt <= '0;
                        state   <= IDLE;
                    end
                endcase
            end
        end
    end

    a_push_err_excl: assert property (@(posedge kb_clk) disable iff (rst)
        !(push && frame_err));

endmodule

// ==== verilog/ps2_kbd_top.sv ====
// PS/2 keyboard receiver top
`timescale 1ns/1ps
module ps2_kbd_top #(
    parameter int FIFO_DEPTH  = 8,
    parameter int GAP_TIMEOUT = 5000
) (
    input  logic                              kb_clk,
    input  logic                              rst,
    input  logic                              ps2_clk,
    input  logic                              ps2_data,
    input  logic [ps2_pkg::AXIL_ADDR_W-1:0]   awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [ps2_pkg::AXIL_DATA_W-1:0]   wdata,
    input  logic [ps2_pkg::AXIL_DATA_W/8-1:0] wstrb,
    input  logic                              wvalid,
    output logic                              wready,
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  logic                              bready,
    input  logic [ps2_pkg::AXIL_ADDR_W-1:0]   araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [ps2_pkg::AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  logic                              rready
);

    import ps2_pkg::*;

    localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

    logic             sample_stb;           // timer to fsm
    logic             bit_value;
    logic             gap_expired;
    logic             push;                 // fsm to fifo
    scan_code_t       push_code;
    logic             frame_err;            // fsm to regs
    logic             rx_enable;            // regs to fsm
    logic             empty;                // fifo to regs
    logic [LVL_W-1:0] level;
    scan_code_t       head_code;
    logic             overflow;
    logic             pop;                  // regs to fifo
    logic             clear_overflow;

    ps2_edge_timer #(.GAP_TIMEOUT(GAP_TIMEOUT)) edge_timer0 (
        .kb_clk, .rst, .ps2_clk, .ps2_data,
        .sample_stb, .bit_value, .gap_expired
    );

    ps2_frame_fsm frame_fsm0 (
        .kb_clk, .rst, .sample_stb, .bit_value, .gap_expired,
        .rx_enable, .push, .push_code, .frame_err
    );

    scan_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
        .kb_clk, .rst, .push, .push_code, .pop, .clear_overflow,
        .empty, .level, .head_code, .overflow
    );

    kbd_axil_regs #(.FIFO_DEPTH(FIFO_DEPTH)) regs0 (
        .kb_clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .empty, .level, .head_code, .overflow, .frame_err,
        .pop, .clear_overflow, .rx_enable
    );

endmodule

// ==== verilog/ps2_pkg.sv ====
// PS/2 keyboard shared definitions
package ps2_pkg;

    // axi4-lite bus shape
    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    // register byte offsets
    localparam logic [AXIL_ADDR_W-1:0] REG_DATA    = 4'h0; // read pops fifo
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS  = 4'h4; // ready, overflow, level, errors
    localparam logic [AXIL_ADDR_W-1:0] REG_CONTROL = 4'h8; // rx enable, clear strobes

    // register field positions and widths
    localparam int DATA_VALID_BIT   = 8;
    localparam int STAT_READY_BIT   = 0;
    localparam int STAT_OVF_BIT     = 1;
    localparam int STAT_LEVEL_LSB   = 4;
    localparam int STAT_LEVEL_W     = 4;
    localparam int STAT_ERRCNT_LSB  = 8;
    localparam int STAT_ERRCNT_W    = 8;
    localparam int CTRL_RX_EN_BIT   = 0;
    localparam int CTRL_CLR_OVF_BIT = 1;
    localparam int CTRL_CLR_ERR_BIT = 2;

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef logic [7:0] scan_code_t; // one keyboard scan code

    // one 11-bit frame, sent lsb first on the wire
    typedef union packed {
        logic [10:0] raw;             // filled bit by bit by the shifter
        struct packed {
            logic       stop;         // must be 1
            logic       parity;       // odd over data and parity
            scan_code_t data;         // scan code, lsb first
            logic       start;        // must be 0
        } fields;
    } ps2_frame_u;

endpackage

// ==== verilog/scan_fifo.sv ====
// scan code FIFO
`timescale 1ns/1ps
module scan_fifo #(
    parameter int FIFO_DEPTH = 8            // power of two, 2 to 16
) (
    input  logic                        kb_clk,
    input  logic                        rst,
    input  logic                        push,
    input  ps2_pkg::scan_code_t         push_code,
    input  logic                        pop,
    input  logic                        clear_overflow,
    output logic                        empty,
    output logic [$clog2(FIFO_DEPTH):0] level,   // 0 .. FIFO_DEPTH
    output ps2_pkg::scan_code_t         head_code, // oldest entry
    output logic                        overflow   // sticky, a code was dropped
);

    import ps2_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    scan_code_t    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;                  // wraps naturally, depth is 2**AW
    logic [AW-1:0] rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full      = (level == (AW+1)'(FIFO_DEPTH));
    assign empty     = (level == '0);
    assign do_push   = push && !full;       // drop on full
    assign do_pop    = pop && !empty;       // ignore pop on empty
    assign head_code = mem[rd_ptr];

    always_ff @(posedge kb_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code;
        end
    end

    always_ff @(posedge kb_clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;    // both or neither
            endcase
            // a drop in the clearing cycle still leaves the flag set
            if (push && full) begin
                overflow <= 1'b1;
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

    a_level_bound: assert property (@(posedge kb_clk) disable iff (rst)
        level <= (AW+1)'(FIFO_DEPTH));

endmodule
